/* Bender.yml */
package:
  name: pipe_controller

sources:
  - files:
      - design/armIsaPkg.sv
      - design/pipeCtrlPkg.sv
      - design/instrDecoder.sv
      - design/condUnit.sv
      - design/memMask.sv
      - design/flagReg.sv
      - design/stageControl.sv
      - design/pipeController.sv
  - target: simulation
    files:
      - verification/pipeController_assert.sv
      - verification/pipeControllerTb.sv

/* design/armIsaPkg.sv */
package armIsaPkg;

  typedef logic [31:0] instrT;

  // ========================================
  // Instruction field positions
  // ========================================
  localparam int condMsb     = 31;
  localparam int condLsb     = 28;
  localparam int classMsb    = 27;
  localparam int classLsb    = 26;
  localparam int immBit      = 25;  // I bit
  localparam int opMsb       = 24;
  localparam int opLsb       = 21;
  localparam int upBit       = 23;  // Offset added when set
  localparam int byteBit     = 22;
  localparam int sLoadBit    = 20;  // S bit for data processing, L bit for transfers
  localparam int rdMsb       = 15;
  localparam int rdLsb       = 12;
  localparam int shiftRegBit = 4;   // Register-specified shift

  localparam logic [3:0] pcRegIdx = 4'd15;

  // ========================================
  // Encodings
  // ========================================
  typedef enum logic [3:0] {
    opAnd, opEor, opSub, opRsb, opAdd, opAdc, opSbc, opRsc,
    opTst, opTeq, opCmp, opCmn, opOrr, opMov, opBic, opMvn
  } aluOpE;

  // 4'hF has no entry here
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt, condGt, condLe, condAl
  } condE;

  typedef enum logic [1:0] {
    dataProc  = 2'b00,
    loadStore = 2'b01,
    branch    = 2'b10,
    unused    = 2'b11
  } instrClassE;

endpackage

/* design/condUnit.sv */
`timescale 1ns/1ps

module condUnit import armIsaPkg::*, pipeCtrlPkg::*; (
  input  armIsaPkg::condE condE,
  input  logic            flagWriteE,
  input  flagsT           flagsE,
  input  flagsT           aluFlagsE,
  output logic            condExE,
  output flagsT           flagsNextE
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = flagsE[flagN];
  assign z = flagsE[flagZ];
  assign c = flagsE[flagC];
  assign v = flagsE[flagV];

  // ========================================
  // Condition table
  // ========================================
  always_comb begin
    case (condE)
      condEq:  condExE = z;
      condNe:  condExE = !z;
      condCs:  condExE = c;
      condCc:  condExE = !c;
      condMi:  condExE = n;
      condPl:  condExE = !n;
      condVs:  condExE = v;
      condVc:  condExE = !v;
      condHi:  condExE = c & !z;
      condLs:  condExE = !c | z;
      condGe:  condExE = (n == v);
      condLt:  condExE = (n != v);
      condGt:  condExE = !z & (n == v);
      condLe:  condExE = z | (n != v);
      condAl:  condExE = 1'b1;
      default: condExE = 1'b0;  // NV never executes
    endcase
  end

  // Flags pass through unchanged unless the S bit was set
  assign flagsNextE = flagWriteE ? aluFlagsE : flagsE;

endmodule

/* design/flagReg.sv */
`timescale 1ns/1ps

module flagReg import pipeCtrlPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  flagsT flagsNextM,
  input  logic  setFlagsM,
  input  flagsT flagsNextW,
  input  logic  setFlagsW,
  output flagsT flags,
  output flagsT flagsE
);

  // Architectural NZCV, written only from Writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (setFlagsW) begin
      flags <= flagsNextW;
    end
  end

  // Youngest pending update wins
  always_comb begin
    if (setFlagsM) begin
      flagsE = flagsNextM;
    end else if (setFlagsW) begin
      flagsE = flagsNextW;
    end else begin
      flagsE = flags;
    end
  end

endmodule

/* design/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder import armIsaPkg::*; (
  input  instrT instrD,
  output logic  regWriteD,
  output logic  memWriteD,
  output logic  memtoRegD,
  output logic  branchD,
  output logic  flagWriteD,
  output logic  pcSrcD,
  output logic  aluSrcD,
  output aluOpE aluControlD,
  output logic  byteD
);

  instrClassE instrClass;
  aluOpE      dpOp;
  logic       isLoad;
  logic       lsUndef;
  logic       pcIsDest;

  assign instrClass = instrClassE'(instrD[classMsb:classLsb]);
  assign dpOp       = aluOpE'(instrD[opMsb:opLsb]);
  assign isLoad     = instrD[sLoadBit];
  assign lsUndef    = instrD[immBit] & instrD[shiftRegBit];  // Reserved transfer encoding
  assign pcIsDest   = (instrD[rdMsb:rdLsb] == pcRegIdx);

  always_comb begin
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    memtoRegD   = 1'b0;
    branchD     = 1'b0;
    flagWriteD  = 1'b0;
    aluSrcD     = 1'b0;
    aluControlD = opAnd;
    byteD       = 1'b0;

    unique case (instrClass)
      dataProc: begin
        aluControlD = dpOp;
        aluSrcD     = instrD[immBit];
        // Test and compare only touch the flags
        regWriteD   = !(dpOp inside {opTst, opTeq, opCmp, opCmn});
        flagWriteD  = instrD[sLoadBit];
      end

      loadStore: begin
        if (!lsUndef) begin
          memtoRegD   = isLoad;
          regWriteD   = isLoad;
          memWriteD   = !isLoad;
          aluSrcD     = !instrD[immBit];  // I bit clear means a 12-bit immediate offset
          aluControlD = instrD[upBit] ? opAdd : opSub;
          byteD       = instrD[byteBit];
        end
      end

      branch: begin
        branchD     = 1'b1;
        aluSrcD     = 1'b1;  // PC plus the word offset
        aluControlD = opAdd;
      end

      unused: begin
        // Coprocessor and SWI space, decoded as a no-op
      end
    endcase
  end

  // Any write to R15 redirects fetch
  assign pcSrcD = branchD | (regWriteD & pcIsDest);

endmodule

/* design/memMask.sv */
`timescale 1ns/1ps

module memMask import pipeCtrlPkg::*; (
  input  logic     byteE,
  input  addrLowT  aluResultLowE,
  output byteMaskT byteMaskE
);

  always_comb begin
    if (byteE) begin
      // Little-endian, lane 0 holds address offset 0
      byteMaskE                = '0;
      byteMaskE[aluResultLowE] = 1'b1;
    end else begin
      byteMaskE = fullMask;
    end
  end

endmodule

/* design/pipeController.sv */
`timescale 1ns/1ps

module pipeController import armIsaPkg::*, pipeCtrlPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     instrValid,
  input  instrT    instrD,
  input  flagsT    aluFlagsE,
  input  addrLowT  aluResultLowE,
  output logic     branchTakenE,
  output logic     aluSrcE,
  output aluOpE    aluControlE,
  output logic     memWriteM,
  output byteMaskT byteMaskM,
  output logic     regWriteW,
  output logic     memtoRegW,
  output logic     pcSrcW,
  output logic     pcWrPendingF,
  output flagsT    flags
);

  // Decode outputs
  logic  regWriteD, memWriteD, memtoRegD, branchD, flagWriteD, pcSrcD;
  logic  aluSrcD, byteD;
  aluOpE aluControlD;

  // Execute side
  armIsaPkg::condE condE;
  logic            flagWriteE, byteE, condExE;
  flagsT           flagsE, flagsNextE;
  byteMaskT        byteMaskE;

  // Flag pipeline
  flagsT flagsNextM, flagsNextW;
  logic  setFlagsM, setFlagsW;

  instrDecoder decoder (
    .instrD      (instrD),
    .regWriteD   (regWriteD),
    .memWriteD   (memWriteD),
    .memtoRegD   (memtoRegD),
    .branchD     (branchD),
    .flagWriteD  (flagWriteD),
    .pcSrcD      (pcSrcD),
    .aluSrcD     (aluSrcD),
    .aluControlD (aluControlD),
    .byteD       (byteD)
  );

  stageControl stages (
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .condD        (armIsaPkg::condE'(instrD[condMsb:condLsb])),
    .regWriteD    (regWriteD),
    .memWriteD    (memWriteD),
    .memtoRegD    (memtoRegD),
    .branchD      (branchD),
    .flagWriteD   (flagWriteD),
    .pcSrcD       (pcSrcD),
    .aluSrcD      (aluSrcD),
    .aluControlD  (aluControlD),
    .byteD        (byteD),
    .condExE      (condExE),
    .flagsNextE   (flagsNextE),
    .byteMaskE    (byteMaskE),
    .condE        (condE),
    .flagWriteE   (flagWriteE),
    .byteE        (byteE),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .byteMaskM    (byteMaskM),
    .regWriteW    (regWriteW),
    .memtoRegW    (memtoRegW),
    .pcSrcW       (pcSrcW),
    .pcWrPendingF (pcWrPendingF),
    .flagsNextM   (flagsNextM),
    .setFlagsM    (setFlagsM),
    .flagsNextW   (flagsNextW),
    .setFlagsW    (setFlagsW)
  );

  condUnit cond (
    .condE      (condE),
    .flagWriteE (flagWriteE),
    .flagsE     (flagsE),
    .aluFlagsE  (aluFlagsE),
    .condExE    (condExE),
    .flagsNextE (flagsNextE)
  );

  memMask mask (
    .byteE         (byteE),
    .aluResultLowE (aluResultLowE),
    .byteMaskE     (byteMaskE)
  );

  flagReg nzcv (
    .clk        (clk),
    .rst        (rst),
    .flagsNextM (flagsNextM),
    .setFlagsM  (setFlagsM),
    .flagsNextW (flagsNextW),
    .setFlagsW  (setFlagsW),
    .flags      (flags),
    .flagsE     (flagsE)
  );

endmodule

/* design/pipeCtrlPkg.sv */
package pipeCtrlPkg;

  // ========================================
  // Status flags
  // ========================================
  localparam int flagWidth = 4;

  // Bit order is N Z C V, N at the top
  typedef logic [flagWidth-1:0] flagsT;

  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // ========================================
  // Memory byte lanes
  // ========================================
  localparam int numLanes = 4;

  typedef logic [numLanes-1:0] byteMaskT;  // One bit per byte lane
  typedef logic [1:0]          addrLowT;   // Address bits 1:0

  localparam byteMaskT fullMask = '1;  // Word access, all lanes

endpackage

/* design/stageControl.sv */
`timescale 1ns/1ps

module stageControl import armIsaPkg::*, pipeCtrlPkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            instrValid,
  input  armIsaPkg::condE condD,
  input  logic            regWriteD,
  input  logic            memWriteD,
  input  logic            memtoRegD,
  input  logic            branchD,
  input  logic            flagWriteD,
  input  logic            pcSrcD,
  input  logic            aluSrcD,
  input  aluOpE           aluControlD,
  input  logic            byteD,
  input  logic            condExE,
  input  flagsT           flagsNextE,
  input  byteMaskT        byteMaskE,
  output armIsaPkg::condE condE,
  output logic            flagWriteE,
  output logic            byteE,
  output logic            aluSrcE,
  output aluOpE           aluControlE,
  output logic            branchTakenE,
  output logic            memWriteM,
  output byteMaskT        byteMaskM,
  output logic            regWriteW,
  output logic            memtoRegW,
  output logic            pcSrcW,
  output logic            pcWrPendingF,
  output flagsT           flagsNextM,
  output logic            setFlagsM,
  output flagsT           flagsNextW,
  output logic            setFlagsW
);

  logic regWriteE, memWriteE, memtoRegE, branchE, pcSrcE;
  logic regWriteGatedE, memWriteGatedE, pcSrcGatedE, setFlagsE;
  logic regWriteM, memtoRegM, pcSrcM;

  // ========================================
  // Execute
  // ========================================
  always_ff @(posedge clk) begin
    if (rst || !instrValid) begin  // No strobe loads a bubble
      condE       <= condEq;
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      memtoRegE   <= 1'b0;
      branchE     <= 1'b0;
      flagWriteE  <= 1'b0;
      pcSrcE      <= 1'b0;
      aluSrcE     <= 1'b0;
      aluControlE <= opAnd;
      byteE       <= 1'b0;
    end else begin
      condE       <= condD;
      regWriteE   <= regWriteD;
      memWriteE   <= memWriteD;
      memtoRegE   <= memtoRegD;
      branchE     <= branchD;
      flagWriteE  <= flagWriteD;
      pcSrcE      <= pcSrcD;
      aluSrcE     <= aluSrcD;
      aluControlE <= aluControlD;
      byteE       <= byteD;
    end
  end

  // Condition gating of every architectural write
  assign regWriteGatedE = regWriteE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign pcSrcGatedE    = pcSrcE & condExE;
  assign setFlagsE      = flagWriteE & condExE;
  assign branchTakenE   = branchE & condExE;

  // ========================================
  // Memory and Writeback
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      memWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
      setFlagsM <= 1'b0;
      byteMaskM <= '0;
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW    <= 1'b0;
      setFlagsW <= 1'b0;
    end else begin
      memWriteM <= memWriteGatedE;
      memtoRegM <= memtoRegE;
      regWriteM <= regWriteGatedE;
      pcSrcM    <= pcSrcGatedE;
      setFlagsM <= setFlagsE;
      byteMaskM <= byteMaskE;
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
      pcSrcW    <= pcSrcM;
      setFlagsW <= setFlagsM;
    end
  end

  // Flag values follow the instruction into Memory and Writeback
  always_ff @(posedge clk) begin
    flagsNextM <= flagsNextE;
    flagsNextW <= flagsNextM;
  end

  // Fetch must wait while a PC write is still in flight
  assign pcWrPendingF = (instrValid & pcSrcD) | pcSrcE | pcSrcM;

endmodule

/* filelist.f */
design/armIsaPkg.sv
design/pipeCtrlPkg.sv
design/instrDecoder.sv
design/condUnit.sv
design/memMask.sv
design/flagReg.sv
design/stageControl.sv
design/pipeController.sv
verification/pipeController_assert.sv
verification/pipeControllerTb.sv

/* verification/pipeControllerTb.sv */
`timescale 1ns/1ps

module pipeControllerTb import armIsaPkg::*, pipeCtrlPkg::*; ();

  localparam logic [31:0] dcRegs  = 32'h000F_0FFF;  // Rn and operand field
  localparam logic [31:0] dcBr    = 32'h00FF_FFFF;  // Branch offset
  localparam logic [31:0] dcUndef = 32'h000F_0FEF;  // Keeps bit 4 for the reserved encoding

  typedef struct {
    logic        valid;
    instrT       instr;
    logic [31:0] dc;
    flagsT       aluFlags;
    addrLowT     addrLow;
    logic        brTaken;
    logic        aluSrc;
    aluOpE       aluOp;
    logic        memWrite;
    byteMaskT    mask;      // Zero means not checked
    logic        regWrite;
    logic        memtoReg;
    logic        pcSrc;
    logic        pcWr;      // Decodes as a PC write, before the condition
    flagsT       flags;     // Committed NZCV once this entry retires
  } entryT;

  logic     clk = 1'b0;
  logic     rst;
  logic     instrValid;
  instrT    instrD;
  flagsT    aluFlagsE;
  addrLowT  aluResultLowE;
  logic     branchTakenE, aluSrcE, memWriteM, regWriteW, memtoRegW, pcSrcW, pcWrPendingF;
  aluOpE    aluControlE;
  byteMaskT byteMaskM;
  flagsT    flags;
  entryT    steps[$];

  always #20 clk = ~clk;

  pipeController uut (.*);

  task automatic stopOnError(string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic checkBit(string name, int idx, logic got, logic exp);
    if (got !== exp)
      stopOnError($sformatf("FAIL %s entry %0d: got %h expected %h", name, idx, got, exp));
  endtask

  task automatic checkOp(string name, int idx, aluOpE got, aluOpE exp);
    if (got !== exp)
      stopOnError($sformatf("FAIL %s entry %0d: got %h expected %h", name, idx, got, exp));
  endtask

  task automatic checkMask(string name, int idx, byteMaskT got, byteMaskT exp);
    if (got !== exp)
      stopOnError($sformatf("FAIL %s entry %0d: got %h expected %h", name, idx, got, exp));
  endtask

  task automatic checkFlags(string name, int idx, flagsT got, flagsT exp);
    if (got !== exp)
      stopOnError($sformatf("FAIL %s entry %0d: got %h expected %h", name, idx, got, exp));
  endtask

  task automatic addEntry(logic valid, instrT instr, logic [31:0] dc, flagsT aluFlags,
                          addrLowT addrLow, logic brTaken, logic aluSrc, aluOpE aluOp,
                          logic memWrite, byteMaskT mask, logic regWrite, logic memtoReg,
                          logic pcSrc, logic pcWr, flagsT flags);
    steps.push_back('{valid, instr, dc, aluFlags, addrLow, brTaken, aluSrc, aluOp,
                      memWrite, mask, regWrite, memtoReg, pcSrc, pcWr, flags});
  endtask

  function automatic instrT fillDontCare(instrT base, logic [31:0] dc);
    return (base & ~dc) | ($urandom() & dc);
  endfunction

  // A strobed PC write counts in Decode and Execute, and in Memory once its condition passed
  function automatic logic pcWrInFlight(int c);
    logic pending;
    pending = 1'b0;
    if (c >= 0 && c < steps.size())
      pending = pending | (steps[c].valid & steps[c].pcWr);
    if (c >= 1 && c - 1 < steps.size())
      pending = pending | (steps[c-1].valid & steps[c-1].pcWr);
    if (c >= 2 && c - 2 < steps.size())
      pending = pending | steps[c-2].pcSrc;
    return pending;
  endfunction

  // ========================================
  // Stimulus and expected values
  // ========================================
  task automatic buildTable();
    addEntry(1, 32'hE2801000, dcRegs,  4'h0, 2'd0, 0, 1, opAdd, 0, 4'h0, 1, 0, 0, 0, 4'h0);
    addEntry(1, 32'hE1500000, dcRegs,  4'h6, 2'd0, 0, 0, opCmp, 0, 4'h0, 0, 0, 0, 0, 4'h6);
    addEntry(1, 32'h00802000, dcRegs,  4'hF, 2'd0, 0, 0, opAdd, 0, 4'h0, 1, 0, 0, 0, 4'h6);
    addEntry(1, 32'h10803000, dcRegs,  4'hF, 2'd0, 0, 0, opAdd, 0, 4'h0, 0, 0, 0, 0, 4'h6);
    addEntry(1, 32'h2A000000, dcBr,    4'h0, 2'd0, 1, 1, opAdd, 0, 4'h0, 0, 0, 1, 1, 4'h6);
    addEntry(1, 32'h4A000000, dcBr,    4'h0, 2'd0, 0, 1, opAdd, 0, 4'h0, 0, 0, 0, 1, 4'h6);
    addEntry(1, 32'hE5801000, dcRegs,  4'h0, 2'd3, 0, 1, opAdd, 1, 4'hF, 0, 0, 0, 0, 4'h6);
    addEntry(1, 32'hE5401000, dcRegs,  4'h0, 2'd2, 0, 1, opSub, 1, 4'h4, 0, 0, 0, 0, 4'h6);
    addEntry(1, 32'hE5D02000, dcRegs,  4'h0, 2'd1, 0, 1, opAdd, 0, 4'h2, 1, 1, 0, 0, 4'h6);
    addEntry(1, 32'hE591F000, dcRegs,  4'h0, 2'd0, 0, 1, opAdd, 0, 4'hF, 1, 1, 1, 1, 4'h6);
    addEntry(0, 32'hE5801000, dcRegs,  4'h0, 2'd0, 0, 0, opAnd, 0, 4'h0, 0, 0, 0, 0, 4'h6);
    addEntry(0, 32'hEA000000, dcBr,    4'h0, 2'd0, 0, 0, opAnd, 0, 4'h0, 0, 0, 0, 1, 4'h6);
    addEntry(1, 32'hE7912010, dcUndef, 4'h0, 2'd1, 0, 0, opAnd, 0, 4'h0, 0, 0, 0, 0, 4'h6);
    addEntry(1, 32'hE3A0F000, dcRegs,  4'h0, 2'd0, 0, 1, opMov, 0, 4'h0, 1, 0, 1, 1, 4'h6);
    addEntry(1, 32'h15801000, dcRegs,  4'h0, 2'd0, 0, 1, opAdd, 0, 4'hF, 0, 0, 0, 0, 4'h6);
    addEntry(1, 32'h42901000, dcRegs,  4'h8, 2'd0, 0, 1, opAdd, 0, 4'h0, 0, 0, 0, 0, 4'h6);
    addEntry(1, 32'hE2901000, dcRegs,  4'h9, 2'd0, 0, 1, opAdd, 0, 4'h0, 1, 0, 0, 0, 4'h9);
    addEntry(1, 32'h4A000000, dcBr,    4'h0, 2'd0, 1, 1, opAdd, 0, 4'h0, 0, 0, 1, 1, 4'h9);
    addEntry(1, 32'hEF000000, dcBr,    4'h0, 2'd0, 0, 0, opAnd, 0, 4'h0, 0, 0, 0, 0, 4'h9);
    addEntry(1, 32'hE3100000, dcRegs,  4'h4, 2'd0, 0, 1, opTst, 0, 4'h0, 0, 0, 0, 0, 4'h4);
  endtask

  // Execute-stage inputs trail their instruction by one cycle
  task automatic driveEntry(int c);
    if (c < steps.size()) begin
      instrValid <= steps[c].valid;
      instrD     <= fillDontCare(steps[c].instr, steps[c].dc);
    end else begin
      instrValid <= 1'b0;
      instrD     <= '0;
    end
    if (c >= 1 && c - 1 < steps.size()) begin
      aluFlagsE     <= steps[c-1].aluFlags;
      aluResultLowE <= steps[c-1].addrLow;
    end else begin
      aluFlagsE     <= '0;
      aluResultLowE <= '0;
    end
  endtask

  task automatic checkStages(int c);
    int e;
    int m;
    int w;
    int f;
    e = c - 1;
    m = c - 2;
    w = c - 3;
    f = c - 4;
    checkBit("pcWrPendingF", c, pcWrPendingF, pcWrInFlight(c));
    if (e >= 0 && e < steps.size()) begin
      checkBit("branchTakenE", e, branchTakenE, steps[e].brTaken);
      checkBit("aluSrcE", e, aluSrcE, steps[e].aluSrc);
      checkOp("aluControlE", e, aluControlE, steps[e].aluOp);
    end
    if (m >= 0 && m < steps.size()) begin
      checkBit("memWriteM", m, memWriteM, steps[m].memWrite);
      if (steps[m].mask != '0)
        checkMask("byteMaskM", m, byteMaskM, steps[m].mask);
    end
    if (w >= 0 && w < steps.size()) begin
      checkBit("regWriteW", w, regWriteW, steps[w].regWrite);
      checkBit("memtoRegW", w, memtoRegW, steps[w].memtoReg);
      checkBit("pcSrcW", w, pcSrcW, steps[w].pcSrc);
    end
    if (f >= 0 && f < steps.size())
      checkFlags("flags", f, flags, steps[f].flags);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    int waitCount;
    void'($urandom(32'h8b96a37b));
    rst           = 1'b1;
    instrValid    = 1'b0;
    instrD        = '0;
    aluFlagsE     = '0;
    aluResultLowE = '0;
    buildTable();

    repeat (3) @(posedge clk);
    rst <= 1'b0;

    waitCount = 0;
    @(negedge clk);
    while (regWriteW !== 1'b0) begin
      if (waitCount == 20)
        stopOnError("Timed out waiting for regWriteW to clear after reset");
      @(negedge clk);
      waitCount++;
    end

    for (int c = 0; c < steps.size() + 4; c++) begin
      @(posedge clk);
      driveEntry(c);
      @(negedge clk);  // Outputs settled mid-cycle
      checkStages(c);
      if (uut.assertions.errorCount != 0)
        stopOnError("A bound assertion failed during the run");
    end

    if (uut.assertions.errorCount == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      stopOnError("Bound assertions reported errors during the run");
    end
  end

endmodule

/* verification/pipeController_assert.sv */
`timescale 1ns/1ps

module pipeControllerAssert import armIsaPkg::*, pipeCtrlPkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     branchTakenE,
  input logic     aluSrcE,
  input aluOpE    aluControlE,
  input logic     memWriteM,
  input byteMaskT byteMaskM,
  input logic     regWriteW,
  input logic     memtoRegW,
  input logic     pcSrcW,
  input logic     pcWrPendingF,
  input flagsT    flags
);

  int errorCount = 0;  // Number of failed assertions

  // A taken branch leaves Writeback as a PC write
  branchToPcWrite: assert property (@(posedge clk) disable iff (rst)
    branchTakenE |-> ##2 pcSrcW)
  else begin
    $error("Taken branch did not reach Writeback as a PC write");
    errorCount++;
  end

  storeMaskShape: assert property (@(posedge clk) disable iff (rst)
    memWriteM |-> (byteMaskM == fullMask) || $onehot(byteMaskM))
  else begin
    $error("Store byte mask is neither full nor a single lane");
    errorCount++;
  end

  // ========================================
  // Reset clears every registered output
  // ========================================
  resetClears: assert property (@(posedge clk)
    rst |=> !branchTakenE && !aluSrcE && (aluControlE == opAnd) && !memWriteM
            && (byteMaskM == '0) && !regWriteW && !memtoRegW && !pcSrcW
            && !pcWrPendingF && (flags == '0))
  else begin
    $error("Control outputs not cleared in the cycle after reset");
    errorCount++;
  end

endmodule

bind pipeController pipeControllerAssert assertions (.*);
